// ==== sources.f ====
source/bp_state_pkg.sv
source/bp_port_pkg.sv
source/tagged_table.sv
source/counter_update.sv
source/branch_predictor.sv
bench/branch_predictor_sva.sv
bench/branch_predictor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.
# Exits nonzero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps \
  -f sources.f --top-module branch_predictor_tb \
  -Mdir "$build_dir" -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  exit 1
fi

exit 0

// ==== bench/branch_predictor_tb.sv ====
/*
  Branch predictor testbench
  Reference model of both tables, LFSR stimulus, directed tests,
  value check and the closing verdict
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_tb;

  localparam int index_bits = 3;                     // Same table size as the DUT
  localparam int entries    = 1 << index_bits;
  localparam int max_cycles = 2000;                  // Watchdog limit

  localparam bp_port_pkg::pc_t pc_a = 16'h1234;      // Index 2
  localparam bp_port_pkg::pc_t pc_b = 16'h0a06;      // Index 3
  localparam bp_port_pkg::pc_t pc_c = 16'h2208;      // Index 4
  localparam bp_port_pkg::pc_t pc_d = 16'h6208;      // Index 4, other tag

  logic                        clk;
  logic                        rst;
  bp_port_pkg::fetch_query_t   query;
  bp_port_pkg::decode_update_t update;
  bp_port_pkg::prediction_t    prediction;

  // Reference model of both tables
  logic                      bht_valid  [entries];
  bp_port_pkg::pc_t          bht_tag    [entries];
  bp_state_pkg::pred_state_t bht_state  [entries];
  logic                      btb_valid  [entries];
  bp_port_pkg::pc_t          btb_target [entries];

  logic [31:0] lfsr = 32'ha3dd;
  int          error_count;
  int          check_count;

  branch_predictor #(
    .index_bits (index_bits)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .query      (query),
    .update     (update),
    .prediction (prediction)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                              // 8 ns period

  initial begin
    #(max_cycles * 8);
    $display("Timeout: simulation ran longer than %0d cycles", max_cycles);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [index_bits-1:0] index_of(bp_port_pkg::pc_t pc);
    return pc[index_bits:1];
  endfunction

  function automatic bp_port_pkg::pc_t tag_of(bp_port_pkg::pc_t pc);
    return pc >> (index_bits + 1);                   // Everything above the index
  endfunction

  // One step up on taken, one step down on not taken, clamped at both ends
  function automatic bp_state_pkg::pred_state_t count_step(
    bp_state_pkg::pred_state_t s, logic taken);
    logic [1:0] v;
    v = s;
    if (taken && v != 2'd3) begin
      v = v + 2'd1;
    end else if (!taken && v != 2'd0) begin
      v = v - 2'd1;
    end
    return bp_state_pkg::pred_state_t'(v);
  endfunction

  function automatic bp_port_pkg::prediction_t expected_prediction();
    bp_port_pkg::prediction_t p;
    logic [index_bits-1:0]    idx;
    p   = '0;
    idx = index_of(query.pc);
    if (query.enable) begin
      if (bht_valid[idx]) begin
        p.state = bht_state[idx];
        p.taken = (bht_tag[idx] == tag_of(query.pc)) && bht_state[idx][1];
      end
      if (btb_valid[idx]) begin
        p.target = btb_target[idx];                  // BTB tag is never checked
      end
    end
    return p;
  endfunction

  task automatic model_edge();
    logic [index_bits-1:0] idx;
    idx = index_of(update.pc);
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        bht_valid[i] = 1'b0;
        btb_valid[i] = 1'b0;
      end
    end else if (query.enable) begin
      if (update.wen_bht) begin
        if (bht_valid[idx] && bht_tag[idx] == tag_of(update.pc)) begin
          bht_state[idx] = count_step(update.prev_state, update.taken);
        end else begin
          bht_state[idx] = bp_state_pkg::strong_not_taken;  // New owner starts low
        end
        bht_valid[idx] = 1'b1;
        bht_tag[idx]   = tag_of(update.pc);
      end
      if (update.wen_btb) begin
        btb_valid[idx]  = 1'b1;
        btb_target[idx] = update.target;
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[14:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Four tags only, so aliasing shows up often
  function automatic bp_port_pkg::pc_t random_pc();
    logic [1:0]            tag;
    logic [index_bits-1:0] idx;
    tag = 2'(rand_bits(2));
    idx = index_bits'(rand_bits(index_bits));
    return bp_port_pkg::pc_t'({tag, 10'h000, idx, 1'b0});
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    model_edge();                                    // Model follows the DUT edge
    #1;
  endtask

  task automatic compare_model(string name);
    @(negedge clk);                                  // Outputs settled mid cycle
    check_value(name, 32'(expected_prediction()), 32'(prediction));
  endtask

  task automatic observe(string name, logic taken, logic [1:0] state,
                         bp_port_pkg::pc_t target);
    compare_model(name);
    check_value(name, {13'd0, taken, state, target}, 32'(prediction));
  endtask

  task automatic write_bht(bp_port_pkg::pc_t pc, bp_state_pkg::pred_state_t prev,
                           logic taken);
    update.pc         = pc;
    update.prev_state = prev;
    update.taken      = taken;
    update.wen_bht    = 1'b1;
    compare_model("write_bht");                      // Old contents in the write cycle
    next_cycle();
    update.wen_bht    = 1'b0;
  endtask

  task automatic apply_reset();
    int waited;
    rst          = 1'b1;
    query.enable = 1'b1;
    query.pc     = pc_a;
    repeat (4) next_cycle();
    rst    = 1'b0;
    waited = 0;
    while (prediction !== '0 && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (prediction !== '0) begin
      error_count++;
      $display("Timeout: prediction did not clear after reset");
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic reset_sweep();
    query.enable = 1'b1;
    for (int i = 0; i < entries; i++) begin
      query.pc = bp_port_pkg::pc_t'((i << 12) | (i << 1));  // Every index, varied tags
      observe("reset_sweep", 1'b0, 2'd0, 16'h0);
      next_cycle();
    end
  endtask

  task automatic counter_training();
    logic [1:0]                climb [9];
    bp_state_pkg::pred_state_t seen;
    climb    = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2, 2'd1, 2'd0, 2'd0};  // First write misses
    query.pc = pc_a;
    observe("counter_training", 1'b0, 2'd0, 16'h0);
    seen = prediction.state;
    next_cycle();
    for (int k = 0; k < 9; k++) begin
      write_bht(pc_a, seen, k < 5);                  // Five taken, then four not taken
      observe("counter_training", climb[k][1], climb[k], 16'h0);
      seen = prediction.state;
      next_cycle();
    end
  endtask

  task automatic btb_replace();
    query.pc       = pc_b;
    update.pc      = pc_b;
    update.target  = 16'h4c20;
    update.wen_btb = 1'b1;
    observe("btb_replace", 1'b0, 2'd0, 16'h0);       // Nothing visible yet
    next_cycle();
    update.target  = 16'h7e10;                       // Second write replaces the first
    observe("btb_replace", 1'b0, 2'd0, 16'h4c20);
    next_cycle();
    update.wen_btb = 1'b0;
    observe("btb_replace", 1'b0, 2'd0, 16'h7e10);
    next_cycle();
  endtask

  task automatic tag_aliasing();
    query.pc = pc_c;
    write_bht(pc_c, bp_state_pkg::strong_not_taken, 1'b1);  // Miss, entry starts low
    write_bht(pc_c, bp_state_pkg::weak_taken, 1'b1);        // Hit, steps to strong taken
    observe("tag_aliasing", 1'b1, 2'd3, 16'h0);
    next_cycle();
    query.pc = pc_d;
    observe("tag_aliasing", 1'b0, 2'd3, 16'h0);      // Raw state, but the tag misses
    next_cycle();
    write_bht(pc_d, bp_state_pkg::strong_taken, 1'b1);
    observe("tag_aliasing", 1'b0, 2'd0, 16'h0);      // New owner, strong not taken
    next_cycle();
    write_bht(pc_d, bp_state_pkg::strong_not_taken, 1'b1);  // Hit under the new tag
    write_bht(pc_d, bp_state_pkg::weak_not_taken, 1'b1);    // Now predicts taken
    observe("tag_aliasing", 1'b1, 2'd2, 16'h0);
    next_cycle();
    query.pc = pc_c;
    observe("tag_aliasing", 1'b0, 2'd2, 16'h0);      // Old owner misses
    next_cycle();
  endtask

  task automatic enable_gating();
    query.pc          = pc_b;
    query.enable      = 1'b0;
    update.pc         = pc_d;
    update.prev_state = bp_state_pkg::weak_taken;
    update.taken      = 1'b1;
    update.target     = 16'h5a5a;
    update.wen_bht    = 1'b1;
    update.wen_btb    = 1'b1;
    observe("enable_gating", 1'b0, 2'd0, 16'h0);     // Stored target hidden
    next_cycle();
    update.wen_bht = 1'b0;
    update.wen_btb = 1'b0;
    query.enable   = 1'b1;
    query.pc       = pc_d;
    observe("enable_gating", 1'b1, 2'd2, 16'h0);     // Blocked writes left no trace
    next_cycle();
  endtask

  task automatic random_run();
    for (int n = 0; n < 300; n++) begin
      query.pc          = random_pc();
      query.enable      = (rand_bits(3) != 16'd0);   // Mostly enabled
      update.pc         = lfsr_bit() ? query.pc : random_pc();
      update.prev_state = bp_state_pkg::pred_state_t'(2'(rand_bits(2)));
      update.taken      = lfsr_bit();
      update.target     = rand_bits(16);
      update.wen_bht    = lfsr_bit();
      update.wen_btb    = lfsr_bit();
      compare_model("random_run");
      next_cycle();
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    rst         = 1'b1;
    query       = '0;
    update      = '0;
    apply_reset();
    reset_sweep();
    counter_training();
    btb_replace();
    tag_aliasing();
    enable_gating();
    random_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/branch_predictor_sva.sv ====
/*
  Bound assertions for the branch predictor top level
  Reset clears the prediction, taken needs enable and a BHT hit,
  a disabled predictor answers zero
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_sva (
  input logic                      clk,
  input logic                      rst,
  input bp_port_pkg::fetch_query_t query,
  input bp_port_pkg::prediction_t  prediction,
  input logic                      bht_rd_hit    // BHT read hit inside the DUT
);

  // Cleared tables answer zero in the cycle after reset
  a_reset_clear : assert property (@(posedge clk) rst |=> prediction == '0)
    else $error("prediction not zero after reset");

  a_taken_needs_hit : assert property (@(posedge clk) disable iff (rst)
    prediction.taken |-> query.enable && bht_rd_hit)
    else $error("taken without enable and a BHT hit");

  a_disabled_zero : assert property (@(posedge clk) disable iff (rst)
    !query.enable |-> prediction == '0)
    else $error("prediction not zero while disabled");

endmodule

bind branch_predictor branch_predictor_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .query      (query),
  .prediction (prediction),
  .bht_rd_hit (bht_rd_hit)
);

`default_nettype wire

// ==== source/branch_predictor.sv ====
/*
  Dynamic branch predictor top level
  BHT and BTB built from tagged_table, counter update on the BHT write
  path, prediction formed under the enable and hit rules
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
  parameter int index_bits = 3            // Index width of both tables
) (
  input  logic                        clk,
  input  logic                        rst,
  input  bp_port_pkg::fetch_query_t   query,       // From fetch
  input  bp_port_pkg::decode_update_t update,      // From decode
  output bp_port_pkg::prediction_t    prediction   // To fetch, same cycle
);

  logic                      bht_wr_en;
  logic                      btb_wr_en;
  logic                      bht_rd_hit;
  logic                      bht_wr_hit;
  bp_state_pkg::pred_state_t bht_rd_state;
  bp_state_pkg::pred_state_t bht_next_state;
  bp_port_pkg::pc_t          btb_rd_target;

  // Strobes only count while the predictor is enabled
  assign bht_wr_en = query.enable && update.wen_bht;
  assign btb_wr_en = query.enable && update.wen_btb;

  ////////////////////////////////////////
  // Branch history table
  ////////////////////////////////////////
  tagged_table #(
    .index_bits (index_bits),
    .payload_t  (bp_state_pkg::pred_state_t)
  ) u_bht (
    .clk     (clk),
    .rst     (rst),
    .rd_pc   (query.pc),
    .rd_hit  (bht_rd_hit),
    .rd_data (bht_rd_state),              // Strong not taken when invalid
    .wr_en   (bht_wr_en),
    .wr_pc   (update.pc),
    .wr_hit  (bht_wr_hit),
    .wr_data (bht_next_state)
  );

  counter_update u_counter (
    .prev_state (update.prev_state),
    .taken      (update.taken),
    .tag_hit    (bht_wr_hit),
    .next_state (bht_next_state)
  );

  ////////////////////////////////////////
  // Branch target buffer
  ////////////////////////////////////////
  // Target is read raw, its tag is not checked
  tagged_table #(
    .index_bits (index_bits),
    .payload_t  (bp_port_pkg::pc_t)
  ) u_btb (
    .clk     (clk),
    .rst     (rst),
    .rd_pc   (query.pc),
    .rd_hit  (),
    .rd_data (btb_rd_target),             // Zero when invalid
    .wr_en   (btb_wr_en),
    .wr_pc   (update.pc),
    .wr_hit  (),
    .wr_data (update.target)
  );

  ////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////
  always_comb begin
    prediction = '0;                      // Disabled predictor answers zero
    if (query.enable) begin
      prediction.state  = bht_rd_state;
      prediction.taken  = bht_rd_hit && bht_rd_state[1];  // Taken only on a tag hit
      prediction.target = btb_rd_target;
    end
  end

endmodule

`default_nettype wire

// ==== source/counter_update.sv ====
/*
  2-bit saturating counter next-state logic
  Steps the counter on a tag hit, restarts at strong not taken on a miss
*/
`timescale 1ns/1ps
`default_nettype none

module counter_update (
  input  bp_state_pkg::pred_state_t prev_state,  // State predicted at fetch
  input  logic                      taken,       // Resolved outcome
  input  logic                      tag_hit,     // Entry belongs to this branch
  output bp_state_pkg::pred_state_t next_state   // State to store
);

  ////////////////////////////////////////
  // Counter step
  ////////////////////////////////////////
  always_comb begin
    next_state = bp_state_pkg::strong_not_taken;  // New or aliasing branch
    if (tag_hit) begin
      unique case (prev_state)
        bp_state_pkg::strong_not_taken: begin
          next_state = taken ? bp_state_pkg::weak_not_taken
                             : bp_state_pkg::strong_not_taken;  // Saturate low
        end
        bp_state_pkg::weak_not_taken: begin
          next_state = taken ? bp_state_pkg::weak_taken
                             : bp_state_pkg::strong_not_taken;
        end
        bp_state_pkg::weak_taken: begin
          next_state = taken ? bp_state_pkg::strong_taken
                             : bp_state_pkg::weak_not_taken;
        end
        bp_state_pkg::strong_taken: begin
          next_state = taken ? bp_state_pkg::strong_taken       // Saturate high
                             : bp_state_pkg::weak_taken;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/tagged_table.sv ====
/*
  Direct-mapped tagged table
  Valid bit and tag per entry, payload of a parameter type,
  one combinational read port and one clocked write port
*/
`timescale 1ns/1ps
`default_nettype none

module tagged_table #(
  parameter int  index_bits = 3,                          // Table has 2**index_bits entries
  parameter type payload_t  = bp_state_pkg::pred_state_t  // Stored data type
) (
  input  logic             clk,
  input  logic             rst,
  input  bp_port_pkg::pc_t rd_pc,           // Read address
  output logic             rd_hit,          // Valid entry with matching tag
  output payload_t         rd_data,         // Zero when entry is invalid
  input  logic             wr_en,           // Write strobe
  input  bp_port_pkg::pc_t wr_pc,           // Write address
  output logic             wr_hit,          // Tag hit on the write side
  input  payload_t         wr_data          // Data stored on write
);

  localparam int entries  = 1 << index_bits;
  localparam int pc_bits  = bp_port_pkg::pc_bits;

  // Supported range check at elaboration
  if (index_bits < bp_state_pkg::min_index_bits ||
      index_bits > bp_state_pkg::max_index_bits) begin : g_bad_index
    $error("tagged_table index_bits out of range");
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  bp_state_pkg::entry_meta_t meta [entries];  // Valid and tag, reset
  payload_t                  data [entries];  // Payload, no reset

  logic [index_bits-1:0]     rd_idx;
  logic [index_bits-1:0]     wr_idx;
  bp_state_pkg::tag_t        rd_tag;
  bp_state_pkg::tag_t        wr_tag;
  bp_state_pkg::entry_meta_t rd_meta;
  bp_state_pkg::entry_meta_t wr_meta;

  // Index sits just above bit 0, tag takes the rest
  assign rd_idx = rd_pc[index_bits:1];
  assign wr_idx = wr_pc[index_bits:1];
  assign rd_tag = bp_state_pkg::tag_t'(rd_pc[pc_bits-1:index_bits+1]);
  assign wr_tag = bp_state_pkg::tag_t'(wr_pc[pc_bits-1:index_bits+1]);

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////
  assign rd_meta = meta[rd_idx];
  assign rd_hit  = rd_meta.valid && (rd_meta.tag == rd_tag);
  assign rd_data = rd_meta.valid ? data[rd_idx] : payload_t'(0);  // Empty payload

  // Lookup for read-modify-write users
  assign wr_meta = meta[wr_idx];
  assign wr_hit  = wr_meta.valid && (wr_meta.tag == wr_tag);

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        meta[i].valid <= 1'b0;            // Cleared table never hits
      end
    end else if (wr_en) begin
      meta[wr_idx].valid <= 1'b1;
      meta[wr_idx].tag   <= wr_tag;       // Entry now owned by this PC
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !rst) begin
      data[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/bp_port_pkg.sv ====
/*
  Pipeline-facing package
  PC width and type, fetch query, decode update and prediction structs
*/
`default_nettype none

package bp_port_pkg;

  localparam int pc_bits = 16;            // Instruction address width

  typedef logic [pc_bits-1:0] pc_t;

  // Fetch stage request, answered in the same cycle
  typedef struct packed {
    pc_t  pc;                             // Address now being fetched
    logic enable;                         // Predictor enable
  } fetch_query_t;

  // Resolved branch coming back from decode
  typedef struct packed {
    pc_t                       pc;          // Branch address in decode
    bp_state_pkg::pred_state_t prev_state;  // State predicted at fetch
    logic                      taken;       // Resolved outcome
    pc_t                       target;      // Resolved target
    logic                      wen_bht;     // History table write strobe
    logic                      wen_btb;     // Target buffer write strobe
  } decode_update_t;

  // Answer to fetch
  typedef struct packed {
    logic                      taken;     // Predicted taken
    bp_state_pkg::pred_state_t state;     // Counter state read from BHT
    pc_t                       target;    // Target read from BTB
  } prediction_t;

endpackage

`default_nettype wire

// ==== source/bp_state_pkg.sv ====
/*
  Predictor storage package
  2-bit counter state encoding, tag type and the per-entry metadata
  layout (valid bit plus tag) used by the direct-mapped tables
*/
`default_nettype none

package bp_state_pkg;

  ////////////////////////////////////////
  // Counter states
  ////////////////////////////////////////
  // The top bit of the state is the taken decision
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,             // Predict not taken, saturated
    weak_not_taken   = 2'b01,             // Predict not taken, one step from flip
    weak_taken       = 2'b10,             // Predict taken, one step from flip
    strong_taken     = 2'b11              // Predict taken, saturated
  } pred_state_t;

  ////////////////////////////////////////
  // Table entry layout
  ////////////////////////////////////////
  localparam int min_index_bits = 2;      // Smallest supported table (4 entries)
  localparam int max_index_bits = 6;      // Largest supported table (64 entries)

  // Widest tag, reached at the smallest index (16-bit PC, bit 0 unused)
  localparam int max_tag_bits = 16 - min_index_bits - 1;

  typedef logic [max_tag_bits-1:0] tag_t; // Tags are zero-extended to this width

  // Metadata kept beside each payload
  typedef struct packed {
    logic valid;                          // Entry written since reset
    tag_t tag;                            // Upper PC bits of the writer
  } entry_meta_t;

endpackage

`default_nettype wire
